// File: source/cabs_settings.svh
////////////////////////////////////////////////////////////
// build-time settings for the serial magnitude subsystem
// CABS_LATENCY must match the stage count of cabs_approx
// CABS_OUT_DEPTH is both buffer size and credit limit
////////////////////////////////////////////////////////////

`ifndef CABS_SETTINGS_SVH
`define CABS_SETTINGS_SVH

// channels per frame
`define CABS_NUM_CHANNELS 4

// bits of each of i and q
`define CABS_WORD_WIDTH 16

// pipeline depth of the magnitude unit
`define CABS_LATENCY 3

// output buffer entries
`define CABS_OUT_DEPTH 2

`endif

// File: source/cabs_types_pkg.sv
////////////////////////////////////////////////////////////
// datapath types: samples, frames and magnitudes
// magnitudes are one bit wider than a sample word
////////////////////////////////////////////////////////////

`default_nettype none

`include "cabs_settings.svh"

package cabs_types_pkg;

  // one complex sample, q in the upper word
  typedef struct packed {
    logic signed [`CABS_WORD_WIDTH-1:0] q;
    logic signed [`CABS_WORD_WIDTH-1:0] i;
  } iq_sample_t;

  typedef iq_sample_t [`CABS_NUM_CHANNELS-1:0] sample_frame_t;

  // unsigned magnitude, extra bit for the max + 3/8 min sum
  typedef logic [`CABS_WORD_WIDTH:0] mag_t;

  typedef mag_t [`CABS_NUM_CHANNELS-1:0] mag_frame_t;

  // what leaves the subsystem per frame
  typedef struct packed {
    sample_frame_t samples;
    mag_frame_t    mags;
  } out_frame_t;

endpackage

`default_nettype wire

// File: source/cabs_ctrl_pkg.sv
////////////////////////////////////////////////////////////
// control types: channel index and pipeline tag
// assumes a channel count of at least two
////////////////////////////////////////////////////////////

`default_nettype none

`include "cabs_settings.svh"

package cabs_ctrl_pkg;

  typedef logic [$clog2(`CABS_NUM_CHANNELS)-1:0] chan_idx_t;

  // travels beside each sample through the magnitude pipe
  typedef struct packed {
    logic      valid;
    chan_idx_t chan;
    // final channel of the frame
    logic      last;
  } cabs_tag_t;

endpackage

`default_nettype wire

// File: source/align_delay.sv
////////////////////////////////////////////////////////////
// fixed delay of DEPTH cycles for any packed payload
// every entry clears to zero on reset; DEPTH must be >= 1
////////////////////////////////////////////////////////////

`default_nettype none

module align_delay #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 1
) (
  input  wire logic     clk,
  input  wire logic     rst_n,
  input  wire payload_t din,
  output payload_t      dout
);

  payload_t stages [DEPTH];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int k = 0; k < DEPTH; k++) begin
        stages[k] <= '0;
      end
    end else begin
      stages[0] <= din;
      for (int k = 1; k < DEPTH; k++) begin
        stages[k] <= stages[k-1];
      end
    end
  end

  assign dout = stages[DEPTH-1];

endmodule

`default_nettype wire

// File: source/channel_sequencer.sv
////////////////////////////////////////////////////////////
// upstream must hold s_frame until the accept edge
// s_ready only rises on the last channel, with a free credit
////////////////////////////////////////////////////////////

`default_nettype none

`include "cabs_settings.svh"

module channel_sequencer
  import cabs_types_pkg::*;
  import cabs_ctrl_pkg::*;
(
  input  wire logic          clk,
  input  wire logic          rst_n,
  input  wire logic          s_valid,
  output logic               s_ready,
  input  wire sample_frame_t s_frame,
  input  wire logic          pop,
  output iq_sample_t         sample,
  output cabs_tag_t          tag,
  output logic               accept
);

  localparam chan_idx_t LAST_CHAN = chan_idx_t'(`CABS_NUM_CHANNELS - 1);
  localparam int CREDIT_W = $clog2(`CABS_OUT_DEPTH + 1);

  chan_idx_t           count;
  logic [CREDIT_W-1:0] credits;
  logic                at_last;

  assign at_last = (count == LAST_CHAN);
  assign s_ready = at_last && (credits < CREDIT_W'(`CABS_OUT_DEPTH));
  assign accept  = s_valid && s_ready;

  // current channel out of the held frame
  assign sample = s_frame[count];

  // last channel is issued once, on the accept cycle only
  assign tag.valid = s_valid && (!at_last || s_ready);
  assign tag.chan  = count;
  assign tag.last  = at_last;

  ////////////////////////////////////////////////////////////
  // channel counter
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
    end else if (accept) begin
      count <= '0;
    end else if (s_valid && !at_last) begin
      count <= count + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // credits, one per frame between accept and output transfer
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credits <= '0;
    end else begin
      case ({accept, pop})
        2'b10:   credits <= credits + 1'b1;
        2'b01:   credits <= credits - 1'b1;
        default: credits <= credits;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: source/cabs_approx.sv
////////////////////////////////////////////////////////////
// max(|i|,|q|) + 3/8 min(|i|,|q|), not an exact magnitude
// three stages, no stall; the most negative input saturates
////////////////////////////////////////////////////////////

`default_nettype none

`include "cabs_settings.svh"

module cabs_approx
  import cabs_types_pkg::*;
  import cabs_ctrl_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       rst_n,
  input  wire iq_sample_t sample,
  input  wire cabs_tag_t  tag_in,
  output mag_t            mag,
  output cabs_tag_t       tag_out
);

  localparam int W = `CABS_WORD_WIDTH;

  logic [W-1:0] abs_i;
  logic [W-1:0] abs_q;
  logic [W-1:0] max_v;
  logic [W-1:0] min_v;
  logic [W+1:0] min_x3;
  mag_t         mag_q;

  function automatic logic [W-1:0] abs_sat(input logic signed [W-1:0] x);
    logic [W-1:0] neg;
    neg = W'(-x);
    if (x == {1'b1, {(W-1){1'b0}}}) begin
      abs_sat = {1'b0, {(W-1){1'b1}}};
    end else if (x < 0) begin
      abs_sat = neg;
    end else begin
      abs_sat = x;
    end
  endfunction

  // stage 1: absolute values
  always_ff @(posedge clk) begin
    abs_i <= abs_sat(sample.i);
    abs_q <= abs_sat(sample.q);
  end

  // stage 2: sort into max and min
  always_ff @(posedge clk) begin
    if (abs_i >= abs_q) begin
      max_v <= abs_i;
      min_v <= abs_q;
    end else begin
      max_v <= abs_q;
      min_v <= abs_i;
    end
  end

  // stage 3: 3*min as min*2 + min, then shift by 3
  assign min_x3 = {2'b00, min_v} + {1'b0, min_v, 1'b0};

  always_ff @(posedge clk) begin
    mag_q <= {1'b0, max_v} + mag_t'(min_x3 >> 3);
  end

  assign mag = mag_q;

  // tag rides alongside the data
  align_delay #(
    .payload_t (cabs_tag_t),
    .DEPTH     (`CABS_LATENCY)
  ) tag_delay (
    .clk  (clk),
    .rst_n(rst_n),
    .din  (tag_in),
    .dout (tag_out)
  );

endmodule

`default_nettype wire

// File: source/magnitude_gather.sv
////////////////////////////////////////////////////////////
// gathers per-channel magnitudes by tag channel index
// frame_in must arrive one cycle after the last tag
////////////////////////////////////////////////////////////

`default_nettype none

`include "cabs_settings.svh"

module magnitude_gather
  import cabs_types_pkg::*;
  import cabs_ctrl_pkg::*;
(
  input  wire logic          clk,
  input  wire logic          rst_n,
  input  wire mag_t          mag,
  input  wire cabs_tag_t     tag,
  input  wire sample_frame_t frame_in,
  output logic               push,
  output out_frame_t         frame_out
);

  mag_frame_t mags;

  // slot write, one channel per valid tag
  always_ff @(posedge clk) begin
    if (tag.valid) begin
      mags[tag.chan] <= mag;
    end
  end

  // frame complete the cycle after its last channel
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      push <= 1'b0;
    end else begin
      push <= tag.valid && tag.last;
    end
  end

  // next frame's channel 0 lands only after this cycle
  assign frame_out.samples = frame_in;
  assign frame_out.mags    = mags;

endmodule

`default_nettype wire

// File: source/frame_output_buffer.sv
////////////////////////////////////////////////////////////
// in-order queue of CABS_OUT_DEPTH frames; push never overflows
// because upstream credits bound the frames in flight
////////////////////////////////////////////////////////////

`default_nettype none

`include "cabs_settings.svh"

module frame_output_buffer
  import cabs_types_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       rst_n,
  input  wire logic       push,
  input  wire out_frame_t din,
  output logic            m_valid,
  input  wire logic       m_ready,
  output out_frame_t      m_frame,
  output logic            pop
);

  localparam int DEPTH = `CABS_OUT_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  out_frame_t       mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
    if (p == PTR_W'(DEPTH - 1)) begin
      ptr_next = '0;
    end else begin
      ptr_next = p + 1'b1;
    end
  endfunction

  assign m_valid = (count != '0);
  assign m_frame = mem[rd_ptr];
  assign pop     = m_valid && m_ready;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= din;
    end
  end

  ////////////////////////////////////////////////////////////
  // pointers and occupancy
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: source/cabs_serial_top.sv
////////////////////////////////////////////////////////////
// accept sampled to first m_valid sampled: CABS_LATENCY+2 edges
// when the output buffer is empty; upstream holds s_frame
////////////////////////////////////////////////////////////

`default_nettype none

`include "cabs_settings.svh"

module cabs_serial_top
  import cabs_types_pkg::*;
  import cabs_ctrl_pkg::*;
(
  input  wire logic          clk,
  input  wire logic          rst_n,
  input  wire logic          s_valid,
  output logic               s_ready,
  input  wire sample_frame_t s_frame,
  output logic               m_valid,
  input  wire logic          m_ready,
  output out_frame_t         m_frame
);

  // held frame flagged by its accept pulse
  typedef struct packed {
    logic          valid;
    sample_frame_t samples;
  } frame_slot_t;

  iq_sample_t  sample;
  cabs_tag_t   tag_in;
  cabs_tag_t   tag_out;
  mag_t        mag;
  logic        accept;
  logic        push;
  logic        pop;
  frame_slot_t frame_slot_in;
  frame_slot_t frame_slot_dly;
  out_frame_t  gathered;

  channel_sequencer u_seq (
    .clk    (clk),
    .rst_n  (rst_n),
    .s_valid(s_valid),
    .s_ready(s_ready),
    .s_frame(s_frame),
    .pop    (pop),
    .sample (sample),
    .tag    (tag_in),
    .accept (accept)
  );

  cabs_approx u_cabs (
    .clk    (clk),
    .rst_n  (rst_n),
    .sample (sample),
    .tag_in (tag_in),
    .mag    (mag),
    .tag_out(tag_out)
  );

  ////////////////////////////////////////////////////////////
  // frame delay, one past the magnitude pipe for the gather
  ////////////////////////////////////////////////////////////

  assign frame_slot_in.valid   = accept;
  assign frame_slot_in.samples = s_frame;

  align_delay #(
    .payload_t (frame_slot_t),
    .DEPTH     (`CABS_LATENCY + 1)
  ) u_frame_delay (
    .clk  (clk),
    .rst_n(rst_n),
    .din  (frame_slot_in),
    .dout (frame_slot_dly)
  );

  magnitude_gather u_gather (
    .clk      (clk),
    .rst_n    (rst_n),
    .mag      (mag),
    .tag      (tag_out),
    .frame_in (frame_slot_dly.samples),
    .push     (push),
    .frame_out(gathered)
  );

  frame_output_buffer u_obuf (
    .clk    (clk),
    .rst_n  (rst_n),
    .push   (push),
    .din    (gathered),
    .m_valid(m_valid),
    .m_ready(m_ready),
    .m_frame(m_frame),
    .pop    (pop)
  );

endmodule

`default_nettype wire

// File: tb/cabs_serial_assertions.sv
////////////////////////////////////////////////////////////
// handshake, credit and frame alignment checks, bound into
// cabs_serial_top; reads buffer occupancy through the hierarchy
////////////////////////////////////////////////////////////

`default_nettype none

`include "cabs_settings.svh"

module cabs_serial_assertions
  import cabs_types_pkg::*;
(
  input wire logic          clk,
  input wire logic          rst_n,
  input wire logic          s_valid,
  input wire logic          s_ready,
  input wire sample_frame_t s_frame,
  input wire logic          m_valid,
  input wire logic          m_ready,
  input wire out_frame_t    m_frame,
  input wire logic          push,
  input wire logic          frame_valid,
  input wire logic [$clog2(`CABS_OUT_DEPTH+1)-1:0] obuf_count
);

  timeunit 1ns;
  timeprecision 1ps;

  // upstream holds its frame until accepted
  a_s_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (s_valid && !s_ready) |=> (s_valid && $stable(s_frame)))
    else $error("s_frame or s_valid changed before the accept");

  a_m_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (m_valid && !m_ready) |=> (m_valid && $stable(m_frame)))
    else $error("m_frame or m_valid changed under back-pressure");

  a_m_reset: assert property (@(posedge clk) !rst_n |-> !m_valid)
    else $error("m_valid high during reset");

  a_credit: assert property (@(posedge clk) disable iff (!rst_n)
    (obuf_count == `CABS_OUT_DEPTH) |-> !s_ready)
    else $error("s_ready high while the output buffer is full");

  // delayed frame must land on the gather push
  a_frame_align: assert property (@(posedge clk) disable iff (!rst_n)
    push == frame_valid)
    else $error("delayed sample frame not aligned with the gather push");

endmodule

bind cabs_serial_top cabs_serial_assertions u_assertions (
  .clk        (clk),
  .rst_n      (rst_n),
  .s_valid    (s_valid),
  .s_ready    (s_ready),
  .s_frame    (s_frame),
  .m_valid    (m_valid),
  .m_ready    (m_ready),
  .m_frame    (m_frame),
  .push       (push),
  .frame_valid(frame_slot_dly.valid),
  .obuf_count (u_obuf.count)
);

`default_nettype wire

// File: tb/cabs_serial_tb.sv
////////////////////////////////////////////////////////////
// drives frames on the falling edge, samples on the rising
// expected frames are built from ref_mag at each accept
////////////////////////////////////////////////////////////

`default_nettype none

`include "cabs_settings.svh"

module cabs_serial_tb
  import cabs_types_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int W             = `CABS_WORD_WIDTH;
  localparam int NCH           = `CABS_NUM_CHANNELS;
  localparam int ACCEPT_LIMIT  = 200;
  localparam int DRAIN_LIMIT   = 2000;
  localparam int HOLD_CYCLES   = 40;
  localparam logic [31:0] LFSR_TAPS = 32'hD000_0001;

  logic          clk;
  logic          rst_n;
  logic          s_valid;
  logic          s_ready;
  sample_frame_t s_frame;
  logic          m_valid;
  logic          m_ready;
  out_frame_t    m_frame;

  out_frame_t    expected [$];
  logic [31:0]   stim_lfsr;
  logic [31:0]   rdy_lfsr;
  int            rdy_mode;
  int            cycle;
  int            accepts;
  int            transfers;
  int            first_accept_cyc;
  int            first_mvalid_cyc;

  cabs_serial_top DUT (
    .clk    (clk),
    .rst_n  (rst_n),
    .s_valid(s_valid),
    .s_ready(s_ready),
    .s_frame(s_frame),
    .m_valid(m_valid),
    .m_ready(m_ready),
    .m_frame(m_frame)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // random source and reference model
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] lfsr_step(input logic [31:0] st);
    if (st[0]) begin
      lfsr_step = (st >> 1) ^ LFSR_TAPS;
    end else begin
      lfsr_step = st >> 1;
    end
  endfunction

  // one lfsr step per bit taken
  task automatic take_bits(input int n, inout logic [31:0] st, output logic [31:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      v  = {v[30:0], st[0]};
      st = lfsr_step(st);
    end
  endtask

  // max(|i|,|q|) + 3*min >> 3, magnitudes clamp to the largest positive word
  function automatic mag_t ref_mag(input iq_sample_t s);
    int ai;
    int aq;
    int hi;
    int lo;
    int top;
    top = (1 << (W - 1)) - 1;
    ai  = (int'(s.i) < 0) ? -int'(s.i) : int'(s.i);
    aq  = (int'(s.q) < 0) ? -int'(s.q) : int'(s.q);
    if (ai > top) ai = top;
    if (aq > top) aq = top;
    hi = (ai > aq) ? ai : aq;
    lo = (ai > aq) ? aq : ai;
    ref_mag = mag_t'(hi + ((3 * lo) >> 3));
  endfunction

  function automatic iq_sample_t make_sample(input int i_val, input int q_val);
    iq_sample_t s;
    s.i = W'(i_val);
    s.q = W'(q_val);
    make_sample = s;
  endfunction

  task automatic rand_frame(output sample_frame_t f);
    logic [31:0] v;
    for (int c = 0; c < NCH; c++) begin
      take_bits(2 * W, stim_lfsr, v);
      f[c] = v;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // failure reporting and compare tasks
  ////////////////////////////////////////////////////////////

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_samples(input sample_frame_t got, input sample_frame_t exp);
    for (int c = 0; c < NCH; c++) begin
      if (got[c] !== exp[c]) begin
        report_failure($sformatf("MISMATCH m_frame.samples[%0d] got %h exp %h",
                                 c, got[c], exp[c]));
      end
    end
  endtask

  task automatic check_mags(input mag_frame_t got, input mag_frame_t exp);
    for (int c = 0; c < NCH; c++) begin
      if (got[c] !== exp[c]) begin
        report_failure($sformatf("MISMATCH m_frame.mags[%0d] got %h exp %h",
                                 c, got[c], exp[c]));
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // monitors: expected queue at each accept, compare at each transfer
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    out_frame_t e;
    if (rst_n) begin
      cycle = cycle + 1;
      if (s_valid && s_ready) begin
        e.samples = s_frame;
        for (int c = 0; c < NCH; c++) begin
          e.mags[c] = ref_mag(s_frame[c]);
        end
        expected.push_back(e);
        accepts++;
        if (first_accept_cyc < 0) first_accept_cyc = cycle;
      end
      if (m_valid && first_mvalid_cyc < 0) first_mvalid_cyc = cycle;
    end
  end

  always @(posedge clk) begin
    out_frame_t e;
    if (rst_n && m_valid && m_ready) begin
      if (expected.size() == 0) begin
        report_failure("output transfer arrived with no frame expected");
      end
      e = expected.pop_front();
      check_samples(m_frame.samples, e.samples);
      check_mags(m_frame.mags, e.mags);
      transfers++;
    end
  end

  // mode 0 ready, mode 1 stalled, mode 2 random
  always @(negedge clk) begin
    logic [31:0] v;
    if (rdy_mode == 2) begin
      take_bits(2, rdy_lfsr, v);
      m_ready = (v[1:0] != 2'b00);
    end else begin
      m_ready = (rdy_mode == 0);
    end
  end

  ////////////////////////////////////////////////////////////
  // upstream driver
  ////////////////////////////////////////////////////////////

  task automatic wait_accept();
    int waited;
    waited = 0;
    @(posedge clk);
    while (!(s_valid && s_ready)) begin
      waited++;
      if (waited > ACCEPT_LIMIT) begin
        report_failure("timeout waiting for the frame to be accepted");
      end
      @(posedge clk);
    end
  endtask

  // called on a falling edge, returns on a falling edge
  task automatic send_frame(input sample_frame_t f, input int gap);
    s_valid = 1'b1;
    s_frame = f;
    wait_accept();
    @(negedge clk);
    if (gap > 0) begin
      s_valid = 1'b0;
      repeat (gap) @(negedge clk);
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (expected.size() != 0 || m_valid) begin
      waited++;
      if (waited > DRAIN_LIMIT) begin
        report_failure("timeout waiting for the output to drain");
      end
      @(negedge clk);
    end
  endtask

  task automatic send_random(input int n);
    sample_frame_t f;
    logic [31:0]   g;
    for (int k = 0; k < n; k++) begin
      rand_frame(f);
      take_bits(2, stim_lfsr, g);
      send_frame(f, int'(g[1:0]));
    end
    s_valid = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    sample_frame_t f;
    rst_n            = 1'b0;
    s_valid          = 1'b0;
    s_frame          = '0;
    m_ready          = 1'b1;
    rdy_mode         = 0;
    stim_lfsr        = 32'd6529;
    rdy_lfsr         = 32'd6529;
    cycle            = 0;
    accepts          = 0;
    transfers        = 0;
    first_accept_cyc = -1;
    first_mvalid_cyc = -1;

    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    // directed values, back to back
    f[0] = make_sample(1000, 0);
    f[1] = make_sample(0, -1000);
    f[2] = make_sample(-2000, 0);
    f[3] = make_sample(0, 2000);
    send_frame(f, 0);
    f[0] = make_sample(500, 500);
    f[1] = make_sample(-500, -500);
    f[2] = make_sample(0, 0);
    f[3] = make_sample(1, 1);
    send_frame(f, 0);
    f[0] = make_sample(-32768, 0);
    f[1] = make_sample(0, -32768);
    f[2] = make_sample(-32768, -32768);
    f[3] = make_sample(32767, -32768);
    send_frame(f, 0);
    f[0] = make_sample(32767, 32767);
    f[1] = make_sample(-1, 0);
    f[2] = make_sample(12345, -6789);
    f[3] = make_sample(0, 0);
    send_frame(f, 1);
    wait_drain();

    // first accept to first m_valid, empty buffer
    if (first_mvalid_cyc - first_accept_cyc != `CABS_LATENCY + 2) begin
      report_failure($sformatf("MISMATCH accept_to_m_valid got %h exp %h",
                               first_mvalid_cyc - first_accept_cyc, `CABS_LATENCY + 2));
    end

    // random frames and gaps, sink always ready
    send_random(20);
    wait_drain();

    // long stall on the output side
    rdy_mode <= 1;
    rand_frame(f);
    send_frame(f, 0);
    rand_frame(f);
    send_frame(f, 0);
    rand_frame(f);
    s_frame = f;
    repeat (HOLD_CYCLES) begin
      @(posedge clk);
      if (s_ready) begin
        report_failure("s_ready rose with two frames outstanding and m_ready low");
      end
    end
    @(negedge clk);
    rdy_mode <= 0;
    wait_accept();
    @(negedge clk);
    s_valid = 1'b0;
    wait_drain();

    // random back-pressure together with random stimulus
    rdy_mode <= 2;
    send_random(30);
    wait_drain();
    rdy_mode <= 0;
    @(negedge clk);

    if (expected.size() == 0 && accepts == transfers) begin
      $display("** PASS **");
      $finish;
    end else begin
      $display("accepted %0d frames but %0d left the DUT", accepts, transfers);
      $display("** FAIL **");
      $fatal(1, "frame count check failed");
    end
  end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+source
source/cabs_types_pkg.sv
source/cabs_ctrl_pkg.sv
source/align_delay.sv
source/channel_sequencer.sv
source/cabs_approx.sv
source/magnitude_gather.sv
source/frame_output_buffer.sv
source/cabs_serial_top.sv
tb/cabs_serial_assertions.sv
tb/cabs_serial_tb.sv

// File: Bender.yml
package:
  name: cabs_serial

sources:
  - include_dirs:
      - source
    files:
      - source/cabs_types_pkg.sv
      - source/cabs_ctrl_pkg.sv
      - source/align_delay.sv
      - source/channel_sequencer.sv
      - source/cabs_approx.sv
      - source/magnitude_gather.sv
      - source/frame_output_buffer.sv
      - source/cabs_serial_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - tb/cabs_serial_assertions.sv
      - tb/cabs_serial_tb.sv
